//--- list.f
mmu_pkg.sv
dtlb.sv
page_walker.sv
xlate_stage.sv
phys_mem.sv
mmu_top.sv
tb_clk_gen.sv
tb_mmu_top.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_mmu_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mmu_top.sv
`timescale 1ns/10ps

module tb_mmu_top;

  import mmu_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int PAGE_WORDS   = 1 << PAGE_OFS_W;
  localparam int MEM_WORDS    = MEM_PAGES * PAGE_WORDS;
  localparam int N_BARE       = 24;
  localparam int N_PTE        = 13;
  localparam int N_XLATE      = 40;
  localparam int TOTAL_CMDS   = 2 * N_BARE + N_PTE + 1 + 4 * N_XLATE;
  localparam int WDOG_CYCLES  = TOTAL_CMDS * 20 + RESET_CYCLES;

  // L1 table in page 1 and L0 tables in pages 2 and 3
  localparam int TBL_L1  = 1;
  localparam int TBL_L0A = 2;
  localparam int TBL_L0B = 3;

  localparam logic [WORD_W-1:0] F_V = WORD_W'(1) << PTE_V_BIT;
  localparam logic [WORD_W-1:0] F_R = WORD_W'(1) << PTE_R_BIT;
  localparam logic [WORD_W-1:0] F_W = WORD_W'(1) << PTE_W_BIT;
  localparam logic [WORD_W-1:0] F_U = WORD_W'(1) << PTE_U_BIT;
  localparam logic [WORD_W-1:0] F_D = WORD_W'(1) << PTE_D_BIT;

  localparam int VPN_POOL_N = 14;
  localparam logic [VPN_W-1:0] VPN_POOL [VPN_POOL_N] = '{
    8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06,
    8'h07, 8'h10, 8'h11, 8'h12, 8'h20, 8'h30, 8'h40};

  logic               clk;
  logic               reset;
  logic               cmd_v;
  mem_op_e            cmd_op;
  logic [VADDR_W-1:0] cmd_vaddr;
  logic [WORD_W-1:0]  cmd_data;
  logic               cmd_ready;
  logic               xlate_en;
  priv_e              priv;
  logic               sum;
  logic [PPN_W-1:0]   base_ppn;
  logic               flush;
  logic               resp_v;
  fault_e             resp_fault;
  logic [WORD_W-1:0]  resp_data;

  integer             seed;
  int                 cycle_cnt = 0;
  logic [WORD_W-1:0]  mem_model [MEM_WORDS];
  fault_e             exp_fault_q [$];
  logic [WORD_W-1:0]  exp_data_q [$];
  bit                 exp_chk_q [$];
  int                 exp_cyc_q [$];

  tb_clk_gen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i
    (.clk_o(clk)
     , .reset_o(reset)
     );

  mmu_top dut_i
    (.clk_i(clk)
     , .reset_i(reset)
     , .cmd_v_i(cmd_v)
     , .cmd_op_i(cmd_op)
     , .cmd_vaddr_i(cmd_vaddr)
     , .cmd_data_i(cmd_data)
     , .cmd_ready_o(cmd_ready)
     , .translation_en_i(xlate_en)
     , .priv_i(priv)
     , .sum_i(sum)
     , .base_ppn_i(base_ppn)
     , .flush_i(flush)
     , .resp_v_o(resp_v)
     , .resp_fault_o(resp_fault)
     , .resp_data_o(resp_data)
     );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [WORD_W-1:0] make_pte(input int ppn, input logic [WORD_W-1:0] flags);
    return (WORD_W'(ppn) << PTE_PPN_LSB) | flags;
  endfunction

  // Reference translation walked over the memory image
  function automatic void predict(input mem_op_e op, input logic [VADDR_W-1:0] vaddr,
                                  output fault_e fault, output int paddr);
    fault_e            pf;
    int                vpn;
    int                pn;
    int                l1_ppn;
    logic [WORD_W-1:0] l1;
    logic [WORD_W-1:0] l0;
    pf    = (op == OP_STORE) ? FAULT_STORE_PAGE : FAULT_LOAD_PAGE;
    vpn   = int'(vaddr) / PAGE_WORDS;
    pn    = vpn;
    fault = FAULT_NONE;
    if (xlate_en && priv != PRIV_M) begin
      l1     = mem_model[int'(base_ppn) * PAGE_WORDS + (vpn >> LVL_IDX_W)];
      l1_ppn = int'(l1[PTE_PPN_LSB +: PPN_W]);
      if (!l1[PTE_V_BIT] || l1[PTE_R_BIT] || l1_ppn >= MEM_PAGES) begin
        fault = pf;
      end else begin
        l0 = mem_model[l1_ppn * PAGE_WORDS + vpn % (1 << LVL_IDX_W)];
        pn = int'(l0[PTE_PPN_LSB +: PPN_W]);
        if (!l0[PTE_V_BIT] || !l0[PTE_R_BIT]) fault = pf;
        else if (priv == PRIV_S && !sum && l0[PTE_U_BIT]) fault = pf;
        else if (priv == PRIV_U && !l0[PTE_U_BIT]) fault = pf;
        else if (op == OP_STORE && !(l0[PTE_W_BIT] && l0[PTE_D_BIT])) fault = pf;
      end
    end
    if (fault == FAULT_NONE && pn >= MEM_PAGES) fault = FAULT_ACCESS;
    paddr = pn * PAGE_WORDS + int'(vaddr) % PAGE_WORDS;
  endfunction

  task automatic send_cmd(input mem_op_e op, input logic [VADDR_W-1:0] vaddr,
                          input logic [WORD_W-1:0] data);
    fault_e fault;
    int     paddr;
    @(negedge clk);
    cmd_v     = 1'b1;
    cmd_op    = op;
    cmd_vaddr = vaddr;
    cmd_data  = data;
    #1;
    while (!cmd_ready) begin
      @(negedge clk);
      #1;
    end
    // Accepted on the coming rising edge
    predict(op, vaddr, fault, paddr);
    exp_fault_q.push_back(fault);
    exp_data_q.push_back(fault == FAULT_NONE ? mem_model[paddr] : '0);
    exp_chk_q.push_back(op == OP_LOAD && fault == FAULT_NONE);
    exp_cyc_q.push_back(xlate_en ? -1 : cycle_cnt);
    if (op == OP_STORE && fault == FAULT_NONE) begin
      mem_model[paddr] = data;
    end
    @(posedge clk);
  endtask

  task automatic write_pte(input int tbl_ppn, input int idx, input logic [WORD_W-1:0] pte);
    send_cmd(OP_STORE, VADDR_W'(tbl_ppn * PAGE_WORDS + idx), pte);
  endtask

  task automatic drain();
    @(negedge clk);
    cmd_v = 1'b0;
    while (exp_fault_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic set_mode(input logic en, input priv_e p, input logic s);
    drain();
    xlate_en = en;
    priv     = p;
    sum      = s;
  endtask

  // Data pages from 4 up where the last few are beyond memory
  function automatic logic [VADDR_W-1:0] bare_addr();
    logic [VPN_W-1:0] vpn;
    vpn = VPN_W'(4 + rand_below(MEM_PAGES));
    return {vpn, PAGE_OFS_W'(rand_below(PAGE_WORDS))};
  endfunction

  task automatic run_random(input int count);
    int               k;
    logic [VPN_W-1:0] vpn;
    mem_op_e          op;
    for (k = 0; k < count; k++) begin
      vpn = VPN_POOL[rand_below(VPN_POOL_N)];
      op  = (rand_below(2) == 0) ? OP_LOAD : OP_STORE;
      send_cmd(op, {vpn, PAGE_OFS_W'(rand_below(PAGE_WORDS))}, $random(seed));
    end
  endtask

  always @(negedge clk) begin
    if (!reset && resp_v) begin
      assert (exp_fault_q.size() != 0)
        else report_error("Response arrived with no command outstanding");
      assert (resp_fault == exp_fault_q[0])
        else report_error($sformatf("[FAIL] resp_fault_o got %h expected %h",
                                    resp_fault, exp_fault_q[0]));
      if (exp_chk_q[0]) begin
        assert (resp_data == exp_data_q[0])
          else report_error($sformatf("[FAIL] resp_data_o got %h expected %h",
                                      resp_data, exp_data_q[0]));
      end
      if (exp_cyc_q[0] >= 0) begin
        assert (cycle_cnt - exp_cyc_q[0] == 2)
          else report_error($sformatf("[FAIL] resp_v_o latency got %h expected %h",
                                      cycle_cnt - exp_cyc_q[0], 2));
      end
      void'(exp_fault_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_chk_q.pop_front());
      void'(exp_cyc_q.pop_front());
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    report_error("Timeout, the DUT stopped answering commands");
  end

  initial begin
    seed      = 32'hde9c_c81e;
    cmd_v     = 1'b0;
    cmd_op    = OP_LOAD;
    cmd_vaddr = '0;
    cmd_data  = '0;
    xlate_en  = 1'b0;
    priv      = PRIV_S;
    sum       = 1'b0;
    base_ppn  = PPN_W'(TBL_L1);
    flush     = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    @(negedge clk);
    while (reset) @(negedge clk);
    assert (cmd_ready && !resp_v)
      else report_error("DUT is not idle after reset");

    // Bare mode
    repeat (N_BARE) send_cmd(OP_STORE, bare_addr(), $random(seed));
    repeat (N_BARE) send_cmd(OP_LOAD, bare_addr(), '0);

    // Level 1 slot 2 stays invalid
    write_pte(TBL_L1, 0, make_pte(TBL_L0A, F_V));
    write_pte(TBL_L1, 1, make_pte(TBL_L0B, F_V));
    write_pte(TBL_L1, 3, make_pte(9, F_V | F_R | F_W | F_D | F_U));
    write_pte(TBL_L1, 4, make_pte(20, F_V));
    write_pte(TBL_L0A, 0, make_pte(4, F_V | F_R | F_W | F_D));
    write_pte(TBL_L0A, 1, make_pte(5, F_V | F_R | F_W | F_D | F_U));
    write_pte(TBL_L0A, 2, make_pte(6, F_V | F_R));
    write_pte(TBL_L0A, 3, make_pte(7, F_V | F_R | F_W | F_U));
    write_pte(TBL_L0A, 5, make_pte(20, F_V | F_R | F_W | F_D | F_U));
    write_pte(TBL_L0A, 6, make_pte(8, F_V | F_R | F_D | F_U));
    write_pte(TBL_L0A, 7, make_pte(9, F_V | F_W | F_D | F_U));
    write_pte(TBL_L0B, 0, make_pte(10, F_V | F_R | F_W | F_D | F_U));
    write_pte(TBL_L0B, 1, make_pte(11, F_V | F_R | F_W | F_D));

    set_mode(1'b1, PRIV_S, 1'b0);
    run_random(N_XLATE);
    set_mode(1'b1, PRIV_S, 1'b1);
    run_random(N_XLATE);
    set_mode(1'b1, PRIV_U, 1'b0);
    run_random(N_XLATE);

    // Remap VPN 0 to page 12 and flush the TLB
    set_mode(1'b0, PRIV_S, 1'b0);
    write_pte(TBL_L0A, 0, make_pte(12, F_V | F_R | F_W | F_D | F_U));
    drain();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    set_mode(1'b1, PRIV_S, 1'b1);
    run_random(N_XLATE);
    drain();

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen
  #(parameter int HALF_PERIOD = 2
    , parameter int RESET_CYCLES = 5)
  (output logic clk_o
   , output logic reset_o
   );

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

//--- mmu_top.sv
`timescale 1ns/10ps

module mmu_top
  (input  logic                          clk_i
   , input  logic                        reset_i
   , input  logic                        cmd_v_i
   , input  mmu_pkg::mem_op_e            cmd_op_i
   , input  logic [mmu_pkg::VADDR_W-1:0] cmd_vaddr_i
   , input  logic [mmu_pkg::WORD_W-1:0]  cmd_data_i
   , output logic                        cmd_ready_o
   , input  logic                        translation_en_i
   , input  mmu_pkg::priv_e              priv_i
   , input  logic                        sum_i
   , input  logic [mmu_pkg::PPN_W-1:0]   base_ppn_i
   , input  logic                        flush_i
   , output logic                        resp_v_o
   , output mmu_pkg::fault_e             resp_fault_o
   , output logic [mmu_pkg::WORD_W-1:0]  resp_data_o
   );

  import mmu_pkg::*;

  logic [VPN_W-1:0]   tlb_vpn;
  logic               tlb_hit;
  logic [WORD_W-1:0]  tlb_pte;
  logic               tlb_fill_v;

  logic               walk_req;
  logic [VPN_W-1:0]   walk_vpn;
  logic               walk_done;
  logic               walk_fault;
  logic [VPN_W-1:0]   fill_vpn;
  logic [WORD_W-1:0]  fill_pte;

  logic               walk_mem_req;
  logic [PADDR_W-1:0] walk_mem_addr;
  logic               cmd_mem_req;
  logic               cmd_mem_we;
  logic [PADDR_W-1:0] cmd_mem_addr;
  logic [WORD_W-1:0]  cmd_mem_wdata;
  logic [WORD_W-1:0]  mem_rdata;

  // Only a clean walk installs an entry
  assign tlb_fill_v  = walk_done & ~walk_fault;
  assign resp_data_o = mem_rdata;

  xlate_stage xlate_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .cmd_v_i(cmd_v_i)
     , .cmd_op_i(cmd_op_i)
     , .cmd_vaddr_i(cmd_vaddr_i)
     , .cmd_data_i(cmd_data_i)
     , .cmd_ready_o(cmd_ready_o)
     , .translation_en_i(translation_en_i)
     , .priv_i(priv_i)
     , .sum_i(sum_i)
     , .tlb_vpn_o(tlb_vpn)
     , .tlb_hit_i(tlb_hit)
     , .tlb_pte_i(tlb_pte)
     , .walk_req_o(walk_req)
     , .walk_vpn_o(walk_vpn)
     , .walk_store_o()
     , .walk_done_i(walk_done)
     , .walk_fault_i(walk_fault)
     , .mem_req_o(cmd_mem_req)
     , .mem_we_o(cmd_mem_we)
     , .mem_addr_o(cmd_mem_addr)
     , .mem_wdata_o(cmd_mem_wdata)
     , .resp_v_o(resp_v_o)
     , .resp_fault_o(resp_fault_o)
     );

  dtlb dtlb_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .flush_i(flush_i)
     , .lookup_vpn_i(tlb_vpn)
     , .hit_o(tlb_hit)
     , .pte_o(tlb_pte)
     , .fill_v_i(tlb_fill_v)
     , .fill_vpn_i(fill_vpn)
     , .fill_pte_i(fill_pte)
     );

  page_walker walker_i
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .base_ppn_i(base_ppn_i)
     , .walk_req_i(walk_req)
     , .walk_vpn_i(walk_vpn)
     , .mem_req_o(walk_mem_req)
     , .mem_addr_o(walk_mem_addr)
     , .mem_rdata_i(mem_rdata)
     , .walk_done_o(walk_done)
     , .walk_fault_o(walk_fault)
     , .fill_vpn_o(fill_vpn)
     , .fill_pte_o(fill_pte)
     );

  phys_mem mem_i
    (.clk_i(clk_i)
     , .walk_req_i(walk_mem_req)
     , .walk_addr_i(walk_mem_addr)
     , .cmd_req_i(cmd_mem_req)
     , .cmd_we_i(cmd_mem_we)
     , .cmd_addr_i(cmd_mem_addr)
     , .cmd_wdata_i(cmd_mem_wdata)
     , .rdata_o(mem_rdata)
     );

endmodule

//--- phys_mem.sv
`timescale 1ns/10ps

module phys_mem
  (input  logic                          clk_i
   , input  logic                        walk_req_i
   , input  logic [mmu_pkg::PADDR_W-1:0] walk_addr_i
   , input  logic                        cmd_req_i
   , input  logic                        cmd_we_i
   , input  logic [mmu_pkg::PADDR_W-1:0] cmd_addr_i
   , input  logic [mmu_pkg::WORD_W-1:0]  cmd_wdata_i
   , output logic [mmu_pkg::WORD_W-1:0]  rdata_o
   );

  import mmu_pkg::*;

  logic [WORD_W-1:0] mem_r [2**PADDR_W];
  logic [WORD_W-1:0] rdata_r;

  initial begin
    for (int i = 0; i < 2**PADDR_W; i++) begin
      mem_r[i] = '0;
    end
  end

  // Walker has priority as the command path stalls during a walk
  always_ff @(posedge clk_i) begin
    if (walk_req_i) begin
      rdata_r <= mem_r[walk_addr_i];
    end else if (cmd_req_i) begin
      if (cmd_we_i) begin
        mem_r[cmd_addr_i] <= cmd_wdata_i;
      end
      // Store returns the old word
      rdata_r <= mem_r[cmd_addr_i];
    end
  end

  assign rdata_o = rdata_r;

endmodule

//--- xlate_stage.sv
`timescale 1ns/10ps

module xlate_stage
  (input  logic                          clk_i
   , input  logic                        reset_i
   , input  logic                        cmd_v_i
   , input  mmu_pkg::mem_op_e            cmd_op_i
   , input  logic [mmu_pkg::VADDR_W-1:0] cmd_vaddr_i
   , input  logic [mmu_pkg::WORD_W-1:0]  cmd_data_i
   , output logic                        cmd_ready_o
   , input  logic                        translation_en_i
   , input  mmu_pkg::priv_e              priv_i
   , input  logic                        sum_i
   , output logic [mmu_pkg::VPN_W-1:0]   tlb_vpn_o
   , input  logic                        tlb_hit_i
   , input  logic [mmu_pkg::WORD_W-1:0]  tlb_pte_i
   , output logic                        walk_req_o
   , output logic [mmu_pkg::VPN_W-1:0]   walk_vpn_o
   , output logic                        walk_store_o
   , input  logic                        walk_done_i
   , input  logic                        walk_fault_i
   , output logic                        mem_req_o
   , output logic                        mem_we_o
   , output logic [mmu_pkg::PADDR_W-1:0] mem_addr_o
   , output logic [mmu_pkg::WORD_W-1:0]  mem_wdata_o
   , output logic                        resp_v_o
   , output mmu_pkg::fault_e             resp_fault_o
   );

  import mmu_pkg::*;

  logic               cmd_v_r;
  mem_op_e            op_r;
  logic [VADDR_W-1:0] vaddr_r;
  logic [WORD_W-1:0]  data_r;
  logic               resp_v_r;
  fault_e             resp_fault_r;

  logic               xlate_on;
  logic               is_store;
  logic [VPN_W-1:0]   vpn;
  logic [VPN_W-1:0]   phys_pn;
  logic               pte_u;
  logic               priv_fault;
  logic               write_fault;
  logic               done;
  fault_e             page_fault_code;
  fault_e             fault;

  // M mode bypasses translation
  assign xlate_on = translation_en_i & (priv_i != PRIV_M);
  assign is_store = (op_r == OP_STORE);
  assign vpn      = vaddr_r[VADDR_W-1:PAGE_OFS_W];
  assign pte_u    = tlb_pte_i[PTE_U_BIT];
  assign phys_pn  = xlate_on ? VPN_W'(tlb_pte_i[PTE_PPN_LSB +: PPN_W]) : vpn;

  assign priv_fault  = ((priv_i == PRIV_S) & ~sum_i & pte_u) | ((priv_i == PRIV_U) & ~pte_u);
  assign write_fault = is_store & ~(tlb_pte_i[PTE_W_BIT] & tlb_pte_i[PTE_D_BIT]);
  assign page_fault_code = is_store ? FAULT_STORE_PAGE : FAULT_LOAD_PAGE;

  // A failed walk also retires the command
  assign done = cmd_v_r & (~xlate_on | tlb_hit_i | (walk_done_i & walk_fault_i));

  always_comb begin
    if (xlate_on & ~tlb_hit_i) begin
      fault = page_fault_code;
    end else if (xlate_on & (priv_fault | write_fault)) begin
      fault = page_fault_code;
    end else if (phys_pn >= MEM_PAGES) begin
      fault = FAULT_ACCESS;
    end else begin
      fault = FAULT_NONE;
    end
  end

  assign cmd_ready_o  = ~cmd_v_r | done;
  assign tlb_vpn_o    = vpn;
  assign walk_req_o   = cmd_v_r & xlate_on & ~tlb_hit_i;
  assign walk_vpn_o   = vpn;
  assign walk_store_o = is_store;

  assign mem_req_o   = done & (fault == FAULT_NONE);
  assign mem_we_o    = is_store;
  assign mem_addr_o  = {phys_pn[PADDR_W-PAGE_OFS_W-1:0], vaddr_r[PAGE_OFS_W-1:0]};
  assign mem_wdata_o = data_r;

  assign resp_v_o     = resp_v_r;
  assign resp_fault_o = resp_fault_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r  <= 1'b0;
      resp_v_r <= 1'b0;
    end else begin
      if (cmd_v_i & cmd_ready_o) begin
        cmd_v_r <= 1'b1;
      end else if (done) begin
        cmd_v_r <= 1'b0;
      end
      resp_v_r <= done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i & cmd_ready_o) begin
      op_r    <= cmd_op_i;
      vaddr_r <= cmd_vaddr_i;
      data_r  <= cmd_data_i;
    end
    if (done) begin
      resp_fault_r <= fault;
    end
  end

endmodule

//--- page_walker.sv
`timescale 1ns/10ps

module page_walker
  (input  logic                          clk_i
   , input  logic                        reset_i
   , input  logic [mmu_pkg::PPN_W-1:0]   base_ppn_i
   , input  logic                        walk_req_i
   , input  logic [mmu_pkg::VPN_W-1:0]   walk_vpn_i
   , output logic                        mem_req_o
   , output logic [mmu_pkg::PADDR_W-1:0] mem_addr_o
   , input  logic [mmu_pkg::WORD_W-1:0]  mem_rdata_i
   , output logic                        walk_done_o
   , output logic                        walk_fault_o
   , output logic [mmu_pkg::VPN_W-1:0]   fill_vpn_o
   , output logic [mmu_pkg::WORD_W-1:0]  fill_pte_o
   );

  import mmu_pkg::*;

  walk_state_e          state_r;
  logic                 rd_pend_r;
  logic                 fault_r;
  logic [VPN_W-1:0]     vpn_r;
  logic [WORD_W-1:0]    pte_r;

  logic [PPN_W-1:0]     tbl_ppn;
  logic [LVL_IDX_W-1:0] lvl_idx;
  logic                 tbl_ok;

  // Table page comes from the base register or the level-1 entry
  assign tbl_ppn = (state_r == WALK_L1) ? base_ppn_i : pte_r[PTE_PPN_LSB +: PPN_W];
  assign lvl_idx = (state_r == WALK_L1) ? vpn_r[VPN_W-1 -: LVL_IDX_W] : vpn_r[LVL_IDX_W-1:0];

  // Level-1 entry must point to a table and not to a leaf
  assign tbl_ok = (tbl_ppn < MEM_PAGES)
                & ((state_r == WALK_L1) | (pte_r[PTE_V_BIT] & ~pte_r[PTE_R_BIT]));

  assign mem_req_o  = ((state_r == WALK_L1) | (state_r == WALK_L0)) & ~rd_pend_r & tbl_ok;
  assign mem_addr_o = {tbl_ppn[PADDR_W-PAGE_OFS_W-1:0],
                       {(PAGE_OFS_W-LVL_IDX_W){1'b0}},
                       lvl_idx};

  assign walk_done_o  = (state_r == WALK_FILL);
  assign walk_fault_o = fault_r | ~pte_r[PTE_V_BIT] | ~pte_r[PTE_R_BIT];
  assign fill_vpn_o   = vpn_r;
  assign fill_pte_o   = pte_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= WALK_IDLE;
      rd_pend_r <= 1'b0;
      fault_r   <= 1'b0;
    end else begin
      case (state_r)
        WALK_IDLE: begin
          if (walk_req_i) begin
            state_r   <= WALK_L1;
            rd_pend_r <= 1'b0;
            fault_r   <= 1'b0;
          end
        end
        WALK_L1, WALK_L0: begin
          if (!rd_pend_r) begin
            if (tbl_ok) begin
              rd_pend_r <= 1'b1;
            end else begin
              fault_r <= 1'b1;
              state_r <= WALK_FILL;
            end
          end else begin
            rd_pend_r <= 1'b0;
            state_r   <= (state_r == WALK_L1) ? WALK_L0 : WALK_FILL;
          end
        end
        default: begin
          state_r <= WALK_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == WALK_IDLE) & walk_req_i) begin
      vpn_r <= walk_vpn_i;
    end
    // Read data is one cycle behind the request
    if (rd_pend_r) begin
      pte_r <= mem_rdata_i;
    end
  end

endmodule

//--- dtlb.sv
`timescale 1ns/10ps

module dtlb
  (input  logic                          clk_i
   , input  logic                        reset_i
   , input  logic                        flush_i
   , input  logic [mmu_pkg::VPN_W-1:0]   lookup_vpn_i
   , output logic                        hit_o
   , output logic [mmu_pkg::WORD_W-1:0]  pte_o
   , input  logic                        fill_v_i
   , input  logic [mmu_pkg::VPN_W-1:0]   fill_vpn_i
   , input  logic [mmu_pkg::WORD_W-1:0]  fill_pte_i
   );

  import mmu_pkg::*;

  logic [VPN_W-1:0]       tag_r [TLB_ENTRIES];
  logic [WORD_W-1:0]      pte_r [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] valid_r;
  logic [TLB_IDX_W-1:0]   victim_r;

  logic [TLB_ENTRIES-1:0] lookup_match;
  logic [TLB_ENTRIES-1:0] fill_match;
  logic [TLB_IDX_W-1:0]   fill_idx;

  // Fully associative compare where at most one entry matches
  always_comb begin
    pte_o    = '0;
    fill_idx = victim_r;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      lookup_match[i] = valid_r[i] & (tag_r[i] == lookup_vpn_i);
      fill_match[i]   = valid_r[i] & (tag_r[i] == fill_vpn_i);
      if (lookup_match[i]) begin
        pte_o = pte_o | pte_r[i];
      end
      // Refill of a present VPN reuses its slot
      if (fill_match[i]) begin
        fill_idx = TLB_IDX_W'(i);
      end
    end
  end

  assign hit_o = |lookup_match;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
      if (~|fill_match) begin
        victim_r <= victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_idx] <= fill_vpn_i;
      pte_r[fill_idx] <= fill_pte_i;
    end
  end

endmodule

//--- mmu_pkg.sv
package mmu_pkg;

  // Word and address widths
  localparam int WORD_W     = 32;
  localparam int VADDR_W    = 14;
  localparam int PAGE_OFS_W = 6;
  localparam int VPN_W      = VADDR_W - PAGE_OFS_W;
  localparam int LVL_IDX_W  = 4;
  localparam int PPN_W      = 6;

  // Installed memory in pages of 64 words
  localparam int MEM_PAGES  = 16;
  localparam int PADDR_W    = $clog2(MEM_PAGES) + PAGE_OFS_W;

  localparam int TLB_ENTRIES = 4;
  localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

  // PTE layout
  localparam int PTE_V_BIT   = 0;
  localparam int PTE_R_BIT   = 1;
  localparam int PTE_W_BIT   = 2;
  localparam int PTE_U_BIT   = 3;
  localparam int PTE_D_BIT   = 4;
  localparam int PTE_PPN_LSB = 8;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } mem_op_e;

  // Encodings follow the RISC-V privilege levels
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    FAULT_NONE,
    FAULT_LOAD_PAGE,
    FAULT_STORE_PAGE,
    FAULT_ACCESS
  } fault_e;

  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_L1,
    WALK_L0,
    WALK_FILL
  } walk_state_e;

endpackage
